// File: vlog.f
cpz_pkg.sv
core_pkg.sv
instr_decode.sv
stage_pipe.sv
cpz_timer.sv
cpz.sv
cpz_top.sv
tb_clock.sv
cpz_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the CP0 testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f vlog.f --top-module cpz_tb -o sim_cpz
out=$(./obj_dir/sim_cpz 2>&1) || { echo "$out"; exit 1; }
echo "$out"
echo "$out" | grep -q "^Testbench passed$"

// File: cpz_tb.sv
/* CP0 subsystem testbench with LFSR stimulus, a cycle model of decode,
   delay line and coprocessor, per-cycle checks and a watchdog */
`timescale 1ns/10ps

module cpz_tb;
    import core_pkg::*;

    localparam int    D          = 2;                   // PIPE_DEPTH
    localparam word_t HANDLER    = 32'h0000_0100;
    localparam int    NUM_RANDOM = 3000;
    localparam int    NUM_INSTR  = NUM_RANDOM + 200;    // Directed part fits in 200

    logic clk, rst, instr_valid, ovf, irq, rd_valid, exc_request, exc_is_sync;
    logic redirect_valid, checking;
    logic [4:0] rd_rt;
    word_t instr, pc, rd_data, redirect_pc, epc, pc_next;
    logic [15:0] lfsr = 16'd45869;

    // Model state
    cp0_op_t     m_dec;
    cp0_op_t     m_pipe [D];
    logic        m_dv, m_rdv, m_exl, m_ie, m_dc, m_ip_hw, m_ti;
    logic        m_pv [D];
    logic [7:0]  m_im;
    logic [1:0]  m_ip_sw;
    logic [4:0]  m_exc_code, m_rd_rt;
    word_t       m_epc, m_count, m_compare, m_rd_data;

    tb_clock #(.PERIOD(40ns)) i_clock (.clk(clk));

    cpz_top #(.PIPE_DEPTH(D), .HANDLER_ADDR(HANDLER)) i_cpz_top (
        .clk(clk), .rst(rst), .instr_valid(instr_valid), .instr(instr), .pc(pc),
        .ovf(ovf), .irq(irq), .rd_valid(rd_valid), .rd_rt(rd_rt), .rd_data(rd_data),
        .exc_request(exc_request), .exc_is_sync(exc_is_sync),
        .redirect_valid(redirect_valid), .redirect_pc(redirect_pc), .epc(epc)
    );

    // Galois LFSR stepped once per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        logic        b;
        r = '0;
        for (int i = 0; i < n; i++) begin
            b    = lfsr[0];
            lfsr = lfsr >> 1;
            if (b) lfsr = lfsr ^ 16'hB400;
            r = {r[30:0], b};
        end
        return r;
    endfunction

    function automatic word_t mfc0_word(input logic [4:0] rt, input logic [4:0] rd);
        return {6'h10, 5'h00, rt, rd, 8'h00, 3'b000};
    endfunction

    // Payload lands in bits 10:3 with sel left at 0
    function automatic word_t mtc0_word(input logic [4:0] rt, input logic [4:0] rd,
                                        input logic [7:0] pay);
        return {6'h10, 5'h04, rt, rd, pay, 3'b000};
    endfunction

    // Decode rules of the subsystem
    function automatic cp0_op_t model_decode(input word_t w, input word_t p, input logic o);
        cp0_op_t r;
        logic    add;
        add       = (w[31:26] == 6'h00) && (w[5:0] == 6'h20);
        r.rt      = w[20:16];
        r.reg_num = w[15:11];
        r.reg_sel = w[2:0];
        r.wdata   = w;
        r.ovf     = o & add;
        r.pc      = p;
        if (w == 32'h4200_0018)                      r.kind = ERET;
        else if (w[31:26] == 6'h10 && w[25:21] == 0) r.kind = MFC0;
        else if (w[31:26] == 6'h10 && w[25:21] == 4) r.kind = MTC0;
        else if (add)                                r.kind = NONE;
        else                                         r.kind = RSVD;
        return r;
    endfunction

    task automatic check(input logic ok, input string msg);
        assert (ok) else begin
            $display("[FAIL] %0t: %s", $time, msg);
            $display("Testbench failed");
            $fatal(1);
        end
    endtask

    // One cycle of stimulus
    task automatic drive(input logic v, input word_t w, input logic o, input logic i);
        @(posedge clk);
        instr_valid <= v;
        instr       <= w;
        pc          <= pc_next;
        ovf         <= o;
        irq         <= i;
        pc_next      = pc_next + 32'd4;
    endtask

    // ########################################
    // Reference model checked at the falling edge

    always @(negedge clk) begin : model
        cp0_op_t    h;
        logic       hv, is_mf, is_mt, is_er, ri, rsync, exc, sel0, hit;
        logic [7:0] ip;
        word_t      mux;
        if (checking) begin
            hv    = m_pv[D-1];
            h     = m_pipe[D-1];
            is_mf = hv && h.kind == MFC0;
            is_mt = hv && h.kind == MTC0;
            is_er = hv && h.kind == ERET;
            ip    = {m_ti, 4'b0000, m_ip_hw, m_ip_sw};   // Timer in ip[7] and irq in ip[2]
            ri    = hv && h.kind == RSVD;
            rsync = ri | (hv && h.ovf);
            exc   = (rsync | (|(ip & m_im))) & ~m_exl;   // Nothing while EXL

            check(exc_request === exc, $sformatf("exc_request %b, expected %b",
                  exc_request, exc));
            check(exc_is_sync === (exc & rsync), "exc_is_sync mismatch");
            check(redirect_valid === (exc | is_er), "redirect_valid mismatch");
            if (exc | is_er)
                check(redirect_pc === (exc ? HANDLER : m_epc), $sformatf(
                      "redirect_pc %h, expected %h", redirect_pc, exc ? HANDLER : m_epc));
            check(epc === m_epc, $sformatf("epc %h, expected %h", epc, m_epc));
            check(rd_valid === m_rdv, $sformatf("rd_valid %b, expected %b", rd_valid, m_rdv));
            if (m_rdv)
                check(rd_rt === m_rd_rt && rd_data === m_rd_data, $sformatf(
                      "read rt %0d data %h, expected rt %0d data %h",
                      rd_rt, rd_data, m_rd_rt, m_rd_data));

            // Next state from the old values only
            sel0 = h.reg_sel == 3'd0;
            case (h.reg_num)
                5'd9:    mux = m_count;
                5'd11:   mux = m_compare;
                5'd12:   mux = {16'h0, m_im, 6'b0, m_exl, m_ie};
                5'd13:   mux = {1'b0, m_ti, 2'b0, m_dc, 11'h0, ip, 1'b0, m_exc_code, 2'b0};
                5'd14:   mux = m_epc;
                default: mux = '0;
            endcase
            if (!sel0) mux = '0;
            m_rdv = is_mf;
            if (is_mf) begin
                m_rd_rt   = h.rt;
                m_rd_data = mux;
            end
            hit = m_ie & ~m_dc & (m_count == m_compare);
            m_ip_hw = m_ip_hw | (m_ie & irq);
            if (exc) m_exc_code = ri ? 5'h0a : (rsync ? 5'h0c : 5'h00);
            if (is_mt && sel0 && h.reg_num == 5'd14) m_epc = h.wdata;
            else if (exc && rsync)                   m_epc = h.pc - 32'd4;
            else if (exc && hv)                      m_epc = h.pc;
            if (is_mt && sel0 && h.reg_num == 5'd11)    m_ti = 1'b0;
            else if (hit)                               m_ti = 1'b1;
            if (is_mt && sel0 && h.reg_num == 5'd11) m_compare = h.wdata;
            if (is_mt && sel0 && h.reg_num == 5'd9)  m_count = h.wdata;
            else if (!m_dc)                          m_count = m_count + 32'd1;
            if (is_mt && sel0 && h.reg_num == 5'd13) begin
                m_dc    = h.wdata[27];
                m_ip_sw = h.wdata[9:8];
            end
            if (is_mt && sel0 && h.reg_num == 5'd12) begin
                m_im  = h.wdata[15:8];
                m_exl = h.wdata[1];
                m_ie  = h.wdata[0];
            end else if (exc) m_exl = 1'b1;
            else if (is_er)   m_exl = 1'b0;
            for (int i = D - 1; i > 0; i--) begin            // Delay line shift
                m_pv[i]   = m_pv[i-1] & ~exc;
                m_pipe[i] = m_pipe[i-1];
            end
            m_pv[0]   = m_dv & ~exc;
            m_pipe[0] = m_dec;
            m_dv      = instr_valid;
            if (instr_valid) m_dec = model_decode(instr, pc, ovf);
        end
    end

    // Watchdog
    initial begin
        #((NUM_INSTR + 100) * 40ns);
        $display("Timeout: the run did not finish in the expected time");
        $display("Testbench failed");
        $fatal(1);
    end

    // ########################################
    // Stimulus

    initial begin : stim
        logic [2:0]  k;
        logic [4:0]  rt, rd;
        logic [31:0] tmp;
        logic        o, i;
        rst         <= 1'b1;
        instr_valid <= 1'b0;
        instr       <= '0;
        pc          <= '0;
        ovf         <= 1'b0;
        irq         <= 1'b0;
        checking    <= 1'b0;
        pc_next      = 32'h0000_1000;
        m_dv       = 1'b0;
        m_rdv      = 1'b0;
        m_exl      = 1'b0;
        m_ie       = 1'b0;
        m_dc       = 1'b0;
        m_ip_hw    = 1'b0;
        m_ti       = 1'b0;
        m_im       = '0;
        m_ip_sw    = '0;
        m_exc_code = '0;
        m_epc      = '0;
        m_count    = '0;
        m_compare  = '0;
        m_rd_rt    = '0;
        m_rd_data  = '0;
        for (int n = 0; n < D; n++) begin
            m_pv[n] = 1'b0;
        end
        repeat (8) @(posedge clk);
        rst      <= 1'b0;
        checking <= 1'b1;

        // Register write and read back
        drive(1, mtc0_word(5'd1, 5'd12, 8'h03), 0, 0);   // Status with no mask
        drive(1, mtc0_word(5'd2, 5'd14, 8'hA5), 0, 0);
        drive(1, mtc0_word(5'd3, 5'd11, 8'h7E), 0, 0);
        drive(1, mtc0_word(5'd2, 5'd13, 8'h60), 0, 0);   // Both software bits pending
        drive(1, mfc0_word(5'd4, 5'd12), 0, 0);
        drive(1, mfc0_word(5'd5, 5'd14), 0, 0);
        drive(1, mfc0_word(5'd6, 5'd11), 0, 0);
        drive(1, mfc0_word(5'd7, 5'd13), 0, 0);
        drive(1, mfc0_word(5'd8, 5'd9), 0, 0);
        drive(1, mfc0_word(5'd9, 5'd3), 0, 0);           // Unimplemented reads 0
        repeat (4) drive(0, '0, 0, 0);
        // Reserved word drops the later ops in flight
        drive(1, 32'hFFFF_FFFF, 0, 0);
        drive(1, mfc0_word(5'd10, 5'd14), 0, 0);
        drive(1, mfc0_word(5'd11, 5'd13), 0, 0);
        repeat (4) drive(0, '0, 0, 0);
        drive(1, 32'h4200_0018, 0, 0);                   // ERET back to EPC
        repeat (4) drive(0, '0, 0, 0);
        drive(1, {6'h00, 20'h12345, 6'h20}, 1, 0);       // ADD with overflow
        repeat (4) drive(0, '0, 0, 0);
        drive(1, mfc0_word(5'd12, 5'd13), 0, 0);
        drive(1, 32'h4200_0018, 0, 0);
        repeat (4) drive(0, '0, 0, 0);

        // Random mix
        for (int n = 0; n < NUM_RANDOM; n++) begin
            k   = 3'(rand_bits(3));
            rt  = 5'(rand_bits(5));
            tmp = rand_bits(3);
            case (tmp[2:0])
                3'd0: rd = 5'd9;
                3'd1: rd = 5'd11;
                3'd2: rd = 5'd12;
                3'd3: rd = 5'd13;
                3'd4: rd = 5'd14;
                default: rd = 5'(rand_bits(5));
            endcase
            tmp = rand_bits(2);
            o   = tmp[0];
            i   = tmp[1];
            case (k)
                3'd0, 3'd1: drive(1, mfc0_word(rt, rd), o, i);
                3'd2, 3'd3: drive(1, mtc0_word(rt, rd, 8'(rand_bits(8))), o, i);
                3'd4:       drive(1, 32'h4200_0018, o, i);
                3'd5: begin
                    tmp = rand_bits(20);
                    drive(1, {6'h00, tmp[19:0], 6'h20}, o, i);
                end
                3'd6:       drive(1, rand_bits(32), o, i);
                default:    drive(0, '0, o, i);
            endcase
        end
        repeat (D + 6) drive(0, '0, 0, 0);
        $display("Testbench passed");
        $finish;
    end

endmodule

// File: tb_clock.sv
/* Testbench clock source */
`timescale 1ns/10ps

module tb_clock #(
    parameter realtime PERIOD = 40ns
) (
    output logic clk
);

    initial clk = 1'b0;

    always #(PERIOD / 2) clk = ~clk;    // 50% duty

endmodule

// File: cpz_top.sv
/* Top level: decoder, op and instruction delay lines, and coprocessor 0 */
`timescale 1ns/10ps

module cpz_top #(
    parameter int              PIPE_DEPTH   = 2,
    parameter core_pkg::word_t HANDLER_ADDR = 32'h0000_0100
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            instr_valid,
    input  core_pkg::word_t instr,
    input  core_pkg::word_t pc,
    input  logic            ovf,
    input  logic            irq,
    output logic            rd_valid,
    output logic [4:0]      rd_rt,
    output core_pkg::word_t rd_data,
    output logic            exc_request,        // Also flushes both lines
    output logic            exc_is_sync,
    output logic            redirect_valid,
    output core_pkg::word_t redirect_pc,
    output core_pkg::word_t epc
);
    import core_pkg::*;

    cp0_op_t dec_op, head_op;
    logic    dec_valid, head_valid;

    instr_decode i_decode (
        .clk         (clk),
        .rst         (rst),
        .instr_valid (instr_valid),
        .instr       (instr),
        .pc          (pc),
        .ovf         (ovf),
        .op          (dec_op),
        .op_valid    (dec_valid)
    );

    stage_pipe #(.payload_t(cp0_op_t), .DEPTH(PIPE_DEPTH)) i_op_pipe (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (dec_valid),
        .in_data   (dec_op),
        .flush     (exc_request),
        .out_valid (head_valid),
        .out_data  (head_op)
    );

    // Raw word, one stage longer to line up with the head op, for waveforms
    stage_pipe #(.payload_t(word_t), .DEPTH(PIPE_DEPTH + 1)) i_instr_pipe (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (instr_valid),
        .in_data   (instr),
        .flush     (exc_request),
        .out_valid (),
        .out_data  ()
    );

    cpz #(.HANDLER_ADDR(HANDLER_ADDR)) i_cpz (
        .clk            (clk),
        .rst            (rst),
        .op             (head_op),
        .op_valid       (head_valid),
        .irq            (irq),
        .rd_valid       (rd_valid),
        .rd_rt          (rd_rt),
        .rd_data        (rd_data),
        .exc_request    (exc_request),
        .exc_is_sync    (exc_is_sync),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc),
        .epc            (epc)
    );

endmodule

// File: cpz.sv
/* Coprocessor 0: register access, exception priority, EPC/Cause/Status
   update and the redirect address */
`timescale 1ns/10ps

module cpz #(
    parameter core_pkg::word_t HANDLER_ADDR = 32'h0000_0100
) (
    input  logic              clk,
    input  logic              rst,
    input  core_pkg::cp0_op_t op,               // Head op of the pipe
    input  logic              op_valid,
    input  logic              irq,              // Hardware interrupt 0
    output logic              rd_valid,         // MFC0 result
    output logic [4:0]        rd_rt,
    output core_pkg::word_t   rd_data,
    output logic              exc_request,
    output logic              exc_is_sync,
    output logic              redirect_valid,
    output core_pkg::word_t   redirect_pc,
    output core_pkg::word_t   epc
);
    import cpz_pkg::*;
    import core_pkg::*;

    // Op decode at the head
    logic is_mfc0, is_mtc0, is_eret;
    logic req_ri, req_ov, req_sync, req_async;

    // Register selects and write strobes
    logic sel_count, sel_compare, sel_status, sel_cause, sel_epc;
    logic status_we, cause_we, epc_we;

    // CP0 state
    cp0_status_t status_q;                      // Reserved bits stay zero
    logic        dc_q;                          // Cause.DC
    logic [1:0]  ip_sw_q;                       // Software interrupts
    logic        ip_hw_q;                       // Sticky irq, ip[2]
    exc_code_t   exc_code_q;
    word_t       epc_q;

    // Assembled words
    cp0_status_t status_wr;
    cp0_cause_t  cause_wr, cause_rd;
    word_t       count, compare, rd_mux;
    logic        timer_int;

    assign is_mfc0 = op_valid && (op.kind == MFC0);
    assign is_mtc0 = op_valid && (op.kind == MTC0);
    assign is_eret = op_valid && (op.kind == ERET);

    // ########################################
    // Register access

    assign sel_count   = (op.reg_num == CP0_REG_COUNT)   && (op.reg_sel == CP0_SEL_0);
    assign sel_compare = (op.reg_num == CP0_REG_COMPARE) && (op.reg_sel == CP0_SEL_0);
    assign sel_status  = (op.reg_num == CP0_REG_STATUS)  && (op.reg_sel == CP0_SEL_0);
    assign sel_cause   = (op.reg_num == CP0_REG_CAUSE)   && (op.reg_sel == CP0_SEL_0);
    assign sel_epc     = (op.reg_num == CP0_REG_EPC)     && (op.reg_sel == CP0_SEL_0);

    assign status_we = is_mtc0 & sel_status;
    assign cause_we  = is_mtc0 & sel_cause;
    assign epc_we    = is_mtc0 & sel_epc;

    assign status_wr = cp0_status_t'(op.wdata);
    assign cause_wr  = cp0_cause_t'(op.wdata);

    // Cause as software sees it
    always_comb begin
        cause_rd          = '0;
        cause_rd.ti       = timer_int;
        cause_rd.dc       = dc_q;
        cause_rd.ip       = {timer_int, 4'b0, ip_hw_q, ip_sw_q};   // ip[7] is the timer
        cause_rd.exc_code = exc_code_q;
    end

    always_comb begin
        if (sel_count)        rd_mux = count;
        else if (sel_compare) rd_mux = compare;
        else if (sel_status)  rd_mux = word_t'(status_q);
        else if (sel_cause)   rd_mux = word_t'(cause_rd);
        else if (sel_epc)     rd_mux = epc_q;
        else                  rd_mux = '0;      // Unimplemented reads zero
    end

    // Read result leaves one cycle after the head op
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= is_mfc0;
        end
    end

    always_ff @(posedge clk) begin
        if (is_mfc0) begin
            rd_rt   <= op.rt;
            rd_data <= rd_mux;
        end
    end

    // ########################################
    // Exception requests

    // Priority RI, then OV, then interrupts
    assign req_ri    = op_valid && (op.kind == RSVD);
    assign req_ov    = op_valid && op.ovf;
    assign req_sync  = req_ri | req_ov;
    assign req_async = |(cause_rd.ip & status_q.im);   // Pending and unmasked

    assign exc_request = (req_sync | req_async) & ~status_q.exl;   // Blocked at EXL
    assign exc_is_sync = exc_request & req_sync;

    // Handler on exception, EPC on ERET
    assign redirect_valid = exc_request | is_eret;
    assign redirect_pc    = exc_request ? HANDLER_ADDR : epc_q;
    assign epc            = epc_q;

    // ########################################
    // Status and Cause update

    always_ff @(posedge clk) begin
        if (rst) begin
            status_q <= '0;
        end else begin
            if (status_we) begin
                status_q.im <= status_wr.im;
                status_q.ie <= status_wr.ie;
            end
            if (status_we)        status_q.exl <= status_wr.exl;   // Software write wins
            else if (exc_request) status_q.exl <= 1'b1;
            else if (is_eret)     status_q.exl <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            dc_q       <= 1'b0;
            ip_sw_q    <= '0;
            ip_hw_q    <= 1'b0;
            exc_code_q <= EXC_INT;
        end else begin
            if (cause_we) begin
                dc_q    <= cause_wr.dc;
                ip_sw_q <= cause_wr.ip[1:0];
            end
            ip_hw_q <= ip_hw_q | (status_q.ie & irq);   // Cleared only by reset
            if (exc_request) begin
                exc_code_q <= req_ri ? EXC_RI :
                              req_ov ? EXC_OV : EXC_INT;
            end
        end
    end

    // EPC, sync points at the faulting op, async at the next one
    always_ff @(posedge clk) begin
        if (rst) begin
            epc_q <= '0;
        end else if (epc_we) begin
            epc_q <= op.wdata;
        end else if (exc_request) begin
            if (req_sync)      epc_q <= op.pc - word_t'(4);
            else if (op_valid) epc_q <= op.pc;  // Holds with an empty head
        end
    end

    // ########################################
    // Count and Compare

    cpz_timer i_timer (
        .clk        (clk),
        .rst        (rst),
        .compare_we (is_mtc0 & sel_compare),
        .count_we   (is_mtc0 & sel_count),
        .wdata      (op.wdata),
        .count_dis  (dc_q),
        .int_en     (status_q.ie),
        .count      (count),
        .compare    (compare),
        .timer_int  (timer_int)
    );

endmodule

// File: cpz_timer.sv
/* CP0 timer: Count and Compare registers, count disable and the sticky
   timer interrupt flag */
`timescale 1ns/10ps

module cpz_timer (
    input  logic            clk,
    input  logic            rst,
    input  logic            compare_we,         // MTC0 to Compare
    input  logic            count_we,           // MTC0 to Count
    input  core_pkg::word_t wdata,
    input  logic            count_dis,          // Cause.DC
    input  logic            int_en,             // Status.IE
    output core_pkg::word_t count,
    output core_pkg::word_t compare,
    output logic            timer_int
);
    import core_pkg::*;

    logic hit;

    // Match only counts while the timer runs and interrupts are on
    assign hit = int_en & ~count_dis & (count == compare);

    // ########################################
    // Count

    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else if (count_we) begin
            count <= wdata;                     // Load beats the increment
        end else if (!count_dis) begin
            count <= count + word_t'(1);
        end
    end

    // Compare
    always_ff @(posedge clk) begin
        if (rst) begin
            compare <= '0;
        end else if (compare_we) begin
            compare <= wdata;
        end
    end

    // Sticky flag, cleared by any Compare write
    always_ff @(posedge clk) begin
        if (rst) begin
            timer_int <= 1'b0;
        end else if (compare_we) begin
            timer_int <= 1'b0;
        end else if (hit) begin
            timer_int <= 1'b1;
        end
    end

endmodule

// File: stage_pipe.sv
/* Delay line of DEPTH payload stages, one valid bit per stage, with flush */
`timescale 1ns/10ps

module stage_pipe #(
    parameter type payload_t = logic [31:0],
    parameter int  DEPTH     = 2                // At least one stage
) (
    input  logic     clk,
    input  logic     rst,
    input  logic     in_valid,
    input  payload_t in_data,
    input  logic     flush,                     // Drop everything in flight
    output logic     out_valid,
    output payload_t out_data
);

    logic [DEPTH-1:0] valid_q;                  // Stage 0 is the entry
    payload_t         data_q [DEPTH];

    // Valid chain, flush clears every stage at the next edge
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            valid_q <= '0;
        end else begin
            valid_q[0] <= in_valid;
            for (int i = 1; i < DEPTH; i++) begin
                valid_q[i] <= valid_q[i-1];
            end
        end
    end

    // Data shifts every cycle, flush leaves it alone
    always_ff @(posedge clk) begin
        data_q[0] <= in_data;
        for (int i = 1; i < DEPTH; i++) begin
            data_q[i] <= data_q[i-1];
        end
    end

    assign out_valid = valid_q[DEPTH-1];        // Head of the line
    assign out_data  = data_q[DEPTH-1];

endmodule

// File: instr_decode.sv
/* Instruction decoder: registers each valid instruction word and classifies
   it into a CP0 operation */
`timescale 1ns/10ps

module instr_decode (
    input  logic              clk,
    input  logic              rst,
    input  logic              instr_valid,      // One cycle strobe
    input  core_pkg::word_t   instr,
    input  core_pkg::word_t   pc,               // Next PC
    input  logic              ovf,              // ALU overflow for this word
    output core_pkg::cp0_op_t op,
    output logic              op_valid
);
    import core_pkg::*;

    instr_fields_t fields;
    cp0_op_t       op_next;
    logic          is_add;

    assign fields = instr_fields_t'(instr);

    // ADD is the only word allowed to carry overflow
    assign is_add = (fields.opcode == OPC_SPECIAL) && (fields.funct == FUNCT_ADD);

    // ########################################
    // Classification

    always_comb begin
        op_next.rt      = fields.rt;
        op_next.reg_num = fields.rd;            // CP0 register in rd
        op_next.reg_sel = instr[2:0];           // sel sits in the low bits
        op_next.wdata   = instr;                // No GPR file, word is the data
        op_next.ovf     = ovf & is_add;
        op_next.pc      = pc;

        if (instr == ERET_WORD) begin           // Full word match first
            op_next.kind = ERET;
        end else if (fields.opcode == OPC_COP0 && fields.rs == RS_MF) begin
            op_next.kind = MFC0;
        end else if (fields.opcode == OPC_COP0 && fields.rs == RS_MT) begin
            op_next.kind = MTC0;
        end else if (is_add) begin
            op_next.kind = NONE;
        end else begin
            op_next.kind = RSVD;                // Anything else traps
        end
    end

    // ########################################
    // Output register

    always_ff @(posedge clk) begin
        if (rst) begin
            op_valid <= 1'b0;
        end else begin
            op_valid <= instr_valid;
        end
    end

    // Payload loads only on a valid word
    always_ff @(posedge clk) begin
        if (instr_valid) begin
            op <= op_next;
        end
    end

endmodule

// File: core_pkg.sv
/* CPU-side types: instruction word fields and opcodes, CP0 operation kinds
   and the operation struct carried down the pipe */
package core_pkg;

    typedef logic [31:0] word_t;            // Data and address word

    // MIPS R-type style field split
    typedef struct packed {
        logic [5:0] opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } instr_fields_t;

    // Encodings picked out by the decoder
    localparam logic [5:0] OPC_SPECIAL = 6'h00;
    localparam logic [5:0] OPC_COP0    = 6'h10;
    localparam logic [5:0] FUNCT_ADD   = 6'h20;
    localparam logic [4:0] RS_MF       = 5'h00;     // MFC0
    localparam logic [4:0] RS_MT       = 5'h04;     // MTC0
    localparam word_t      ERET_WORD   = 32'h4200_0018;

    // What the coprocessor has to do with an op
    typedef enum logic [2:0] {
        NONE,                               // Plain op, may carry overflow
        MFC0,
        MTC0,
        ERET,
        RSVD                                // Reserved instruction
    } cp0_op_kind_t;

    typedef struct packed {
        cp0_op_kind_t          kind;
        logic [4:0]            rt;          // Target GPR for MFC0 data
        cpz_pkg::cp0_reg_num_t reg_num;
        cpz_pkg::cp0_reg_sel_t reg_sel;
        word_t                 wdata;       // MTC0 write data
        logic                  ovf;         // Overflow seen by the ALU
        word_t                 pc;          // Next PC of this op
    } cp0_op_t;

endpackage

// File: cpz_pkg.sv
/* Coprocessor 0 definitions: register numbers, select codes, exception codes
   and the packed layouts of the Status and Cause words */
package cpz_pkg;

    typedef logic [4:0] cp0_reg_num_t;      // Register number, rd field
    typedef logic [2:0] cp0_reg_sel_t;      // Register select, sel field
    typedef logic [4:0] exc_code_t;         // Cause.ExcCode value

    // ########################################
    // Register numbers and selects

    localparam cp0_reg_num_t CP0_REG_COUNT   = 5'd9;
    localparam cp0_reg_num_t CP0_REG_COMPARE = 5'd11;
    localparam cp0_reg_num_t CP0_REG_STATUS  = 5'd12;
    localparam cp0_reg_num_t CP0_REG_CAUSE   = 5'd13;
    localparam cp0_reg_num_t CP0_REG_EPC     = 5'd14;

    localparam cp0_reg_sel_t CP0_SEL_0       = 3'd0;   // Only select implemented

    // Exception codes
    localparam exc_code_t EXC_INT = 5'h00;  // Interrupt
    localparam exc_code_t EXC_RI  = 5'h0a;  // Reserved instruction
    localparam exc_code_t EXC_OV  = 5'h0c;  // Arithmetic overflow

    // ########################################
    // Status word, unlisted bits read as zero

    typedef struct packed {
        logic [15:0] rsvd_31_16;
        logic [7:0]  im;            // Interrupt mask
        logic [5:0]  rsvd_7_2;
        logic        exl;           // Exception level
        logic        ie;            // Interrupt enable
    } cp0_status_t;

    // Cause word
    typedef struct packed {
        logic        rsvd_31;
        logic        ti;            // Timer interrupt pending
        logic [1:0]  rsvd_29_28;
        logic        dc;            // Count disable
        logic [10:0] rsvd_26_16;
        logic [7:0]  ip;            // Pending interrupts
        logic        rsvd_7;
        exc_code_t   exc_code;      // Last exception code
        logic [1:0]  rsvd_1_0;
    } cp0_cause_t;

endpackage
